// ==== Makefile ====
# Verilator flow for the receive front end
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module spi_rx_top -f sources.f

sim:
	verilator --binary --timing --top-module tb_spi_rx -f sources.f -Mdir obj_dir -o tb_spi_rx
	./obj_dir/tb_spi_rx | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/spi_cmd_decode.sv ====
//**************************************************************************
// Command decoder
//   Splits the live command byte into class and instruction
//   Qualifies WRITE and WRSR with the write enable latch
//   Blocks everything but RDSR while the memory is busy
//**************************************************************************
`timescale 1ns/1ps
module spi_cmd_decode import spi_rx_pkg::*; (
    input  cmd_word_u live_cmd,
    input  logic      ee_wbusy,
    input  logic      wel,
    output logic      dec_wren,
    output logic      dec_wrdi,
    output logic      dec_rdsr,
    output logic      dec_wrsr,
    output logic      dec_read,
    output logic      dec_write
);

    logic is_normal;
    logic hit_wren;
    logic hit_wrdi;
    logic hit_rdsr;
    logic hit_wrsr;
    logic hit_read;
    logic hit_write;
    logic idle;

    assign is_normal = (live_cmd.fld.cls == CMD_CLASS_NORMAL);
    assign idle      = ~ee_wbusy;

    // Raw instruction matches, class checked once here
    assign hit_wren  = is_normal & (live_cmd.fld.ins == INS_WREN);
    assign hit_wrdi  = is_normal & (live_cmd.fld.ins == INS_WRDI);
    assign hit_rdsr  = is_normal & (live_cmd.fld.ins == INS_RDSR);
    assign hit_wrsr  = is_normal & (live_cmd.fld.ins == INS_WRSR);
    assign hit_read  = is_normal & (live_cmd.fld.ins == INS_READ);
    assign hit_write = is_normal & (live_cmd.fld.ins == INS_WRITE);

    // Status read stays legal during an internal write cycle
    assign dec_rdsr  = hit_rdsr;
    assign dec_wren  = hit_wren  & idle;
    assign dec_wrdi  = hit_wrdi  & idle;
    assign dec_read  = hit_read  & idle;
    assign dec_wrsr  = hit_wrsr  & wel & idle;     // Needs prior WREN
    assign dec_write = hit_write & wel & idle;     // Needs prior WREN

endmodule

// ==== hdl/spi_data_path.sv ====
//**************************************************************************
// Address and data path
//   Serial byte shift register and data byte capture
//   Page base and in-page offset, wrapping at the page size
//   Block-protect check
//   Program, read and status-write strobes
//**************************************************************************
`timescale 1ns/1ps
module spi_data_path import spi_rx_pkg::*; (
    input  logic               spi_clk_c,
    input  logic               spi_frm_rst_n,
    input  logic               sda_in,
    input  logic [STATE_W-1:0] cur_state,
    input  logic               bit_last,
    input  logic               cmd_is_read,
    input  logic               cmd_is_write,
    input  logic               cmd_is_wrsr,
    input  logic [1:0]         bp,
    output logic [ADDR_W-1:0]  mem_addr,
    output logic               prog_en,
    output logic [BYTE_W-1:0]  prog_data,
    output logic               rd_strobe,
    output logic               wrsr_commit,
    output logic [BYTE_W-1:0]  data_byte
);

    logic [BYTE_W-2:0]            shift_sr;
    logic [BYTE_W-1:0]            live_byte;
    logic [ADDR_W-PAGE_OFS_W-1:0] page_base;
    logic [PAGE_OFS_W-1:0]        page_ofs;
    logic [PAGE_OFS_W-1:0]        ofs_next;
    logic                         in_wr_phase;
    logic                         wr_byte_done;
    logic                         rd_byte_done;
    logic                         wr_step;
    logic                         addr_prot;

    assign live_byte    = {shift_sr, sda_in};
    assign mem_addr     = {page_base, page_ofs};
    assign prog_data    = data_byte;
    assign in_wr_phase  = (cur_state == ST_BYTE_WR) | (cur_state == ST_PAGE_WR);
    assign wr_byte_done = in_wr_phase & bit_last & cmd_is_write;
    assign rd_byte_done = (cur_state == ST_DAT_RD) & bit_last & cmd_is_read;
    assign ofs_next     = (page_ofs == PAGE_OFS_W'(PAGE_BYTES - 1)) ? '0 : page_ofs + 1'b1;

    // Block protect on the current address
    always_comb begin
        case (bp)
            2'b00:   addr_prot = 1'b0;
            2'b01:   addr_prot = mem_addr[ADDR_W-1] & mem_addr[ADDR_W-2];  // Top quarter
            2'b10:   addr_prot = mem_addr[ADDR_W-1];                       // Upper half
            default: addr_prot = 1'b1;                                     // Whole array
        endcase
    end

    always_ff @(posedge spi_clk_c) begin
        shift_sr <= live_byte[BYTE_W-2:0];
        if (in_wr_phase && bit_last)
            data_byte <= live_byte;
    end

    //**********************************************************************
    // Address counter and strobes
    //**********************************************************************
    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n) begin
            page_base   <= '0;
            page_ofs    <= '0;
            prog_en     <= 1'b0;
            rd_strobe   <= 1'b0;
            wrsr_commit <= 1'b0;
            wr_step     <= 1'b0;
        end else begin
            prog_en     <= wr_byte_done & ~addr_prot;
            rd_strobe   <= rd_byte_done;
            wrsr_commit <= (cur_state == ST_BYTE_WR) & bit_last & cmd_is_wrsr;
            wr_step     <= wr_byte_done;       // Step after the program cycle
            if ((cur_state == ST_ADDR) && bit_last) begin
                page_base <= live_byte[ADDR_W-1:PAGE_OFS_W];
                page_ofs  <= live_byte[PAGE_OFS_W-1:0];
            end else if (rd_byte_done || wr_step) begin
                page_ofs  <= ofs_next;         // Read steps ahead of the strobe
            end
        end
    end

endmodule

// ==== hdl/spi_frame_fsm.sv ====
//**************************************************************************
// Frame control
//   Down-counting bit counter and command shift register
//   Frame state machine
//   Command flags latched for the rest of the frame
//   WREN and WRDI pulses for the write enable latch
//**************************************************************************
`timescale 1ns/1ps
module spi_frame_fsm import spi_rx_pkg::*; (
    input  logic               spi_clk_c,
    input  logic               spi_frm_rst_n,
    input  logic               sda_in,
    input  logic               dec_wren,
    input  logic               dec_wrdi,
    input  logic               dec_rdsr,
    input  logic               dec_wrsr,
    input  logic               dec_read,
    input  logic               dec_write,
    output cmd_word_u          live_cmd,
    output logic [STATE_W-1:0] cur_state,
    output logic               bit_last,
    output logic               cmd_is_read,
    output logic               cmd_is_write,
    output logic               cmd_is_wrsr,
    output logic               wren_set,
    output logic               wrdi_clr,
    output logic               cmd_valid,
    output logic               cmd_err
);

    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [BYTE_W-2:0]    cmd_reg;
    logic [STATE_W-1:0]   nxt_state;
    logic                 cmd_done;
    logic                 any_cmd;

    assign bit_last      = (bit_cnt == '0);
    assign live_cmd.raw  = {cmd_reg, sda_in};  // Byte incl. current bit
    assign cmd_done      = (cur_state == ST_CMD) & bit_last;
    assign any_cmd       = dec_wren | dec_wrdi | dec_rdsr | dec_wrsr | dec_read | dec_write;
    assign wren_set      = cmd_done & dec_wren;
    assign wrdi_clr      = cmd_done & dec_wrdi;

    //**********************************************************************
    // Next state
    //**********************************************************************
    always_comb begin
        nxt_state = cur_state;
        case (cur_state)
            ST_CMD: begin
                if (bit_last) begin
                    if (dec_wren | dec_wrdi)       nxt_state = ST_WAIT;
                    else if (dec_wrsr)             nxt_state = ST_BYTE_WR;
                    else if (dec_rdsr)             nxt_state = ST_DAT_RD;
                    else if (dec_read | dec_write) nxt_state = ST_ADDR;
                    else                           nxt_state = ST_ERR;
                end
            end
            ST_ADDR: begin
                if (bit_last)
                    nxt_state = cmd_is_write ? ST_BYTE_WR : ST_DAT_RD;
            end
            ST_BYTE_WR: begin
                if (bit_last)
                    nxt_state = ST_PAGE_WR;
            end
            default: nxt_state = cur_state;    // Terminal states hold
        endcase
    end

    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n) begin
            cur_state    <= ST_CMD;
            bit_cnt      <= '1;                // MSB first from 7 down to 0
            cmd_reg      <= '0;
            cmd_is_read  <= 1'b0;
            cmd_is_write <= 1'b0;
            cmd_is_wrsr  <= 1'b0;
            cmd_valid    <= 1'b0;
            cmd_err      <= 1'b0;
        end else begin
            cur_state <= nxt_state;
            bit_cnt   <= bit_cnt - 1'b1;       // Wraps to 7 after zero
            if (cur_state == ST_CMD)
                cmd_reg <= live_cmd.raw[BYTE_W-2:0];
            if (cmd_done) begin
                cmd_is_read  <= dec_read;
                cmd_is_write <= dec_write;
                cmd_is_wrsr  <= dec_wrsr;
                cmd_valid    <= 1'b1;
                cmd_err      <= ~any_cmd;
            end
        end
    end

endmodule

// ==== hdl/spi_rx_pkg.sv ====
//**************************************************************************
// Shared definitions for the serial EEPROM receive front end
//   Frame state codes and instruction codes
//   Byte, counter, page and address widths
//   Status register bit positions
//   Command byte union, raw shift view and field view
//**************************************************************************
package spi_rx_pkg;

    //**********************************************************************
    // Frame states
    //**********************************************************************
    localparam int          STATE_W    = 3;
    localparam logic [2:0]  ST_CMD     = 3'b000;   // Command byte
    localparam logic [2:0]  ST_ADDR    = 3'b001;   // Address byte
    localparam logic [2:0]  ST_BYTE_WR = 3'b010;   // First data byte
    localparam logic [2:0]  ST_PAGE_WR = 3'b110;   // Further data bytes
    localparam logic [2:0]  ST_DAT_RD  = 3'b111;   // Read phase
    localparam logic [2:0]  ST_WAIT    = 3'b101;   // One-byte command done
    localparam logic [2:0]  ST_ERR     = 3'b100;   // Illegal or refused

    // Instruction field codes
    localparam int          CLASS_W          = 4;
    localparam int          INS_W            = 3;
    localparam logic [2:0]  INS_WREN         = 3'b110;
    localparam logic [2:0]  INS_WRDI         = 3'b100;
    localparam logic [2:0]  INS_RDSR         = 3'b101;
    localparam logic [2:0]  INS_WRSR         = 3'b001;
    localparam logic [2:0]  INS_READ         = 3'b011;
    localparam logic [2:0]  INS_WRITE        = 3'b010;
    localparam logic [3:0]  CMD_CLASS_NORMAL = 4'b0000;

    // Sizes
    localparam int BYTE_W     = 8;
    localparam int BIT_CNT_W  = 3;
    localparam int PAGE_BYTES = 8;
    localparam int PAGE_OFS_W = 3;
    localparam int ADDR_W     = 8;

    // Status register layout
    localparam int SR_SRWD  = 7;
    localparam int SR_BP_HI = 3;
    localparam int SR_BP_LO = 2;
    localparam int SR_WEL   = 1;
    localparam int SR_WIP   = 0;

    typedef union packed {
        logic [BYTE_W-1:0] raw;         // As shifted in
        struct packed {
            logic [CLASS_W-1:0] cls;    // Zero for normal commands
            logic               rsvd;
            logic [INS_W-1:0]   ins;
        } fld;
    } cmd_word_u;

endpackage

// ==== hdl/spi_rx_top.sv ====
//**************************************************************************
// Receive front end top level
//   Frame FSM, command decoder, data path and status register
//**************************************************************************
`timescale 1ns/1ps
module spi_rx_top import spi_rx_pkg::*; (
    input  logic              spi_clk_c,
    input  logic              spi_frm_rst_n,
    input  logic              spi_sys_rst_n,
    input  logic              sda_in,
    input  logic              spi_wp_n,
    input  logic              ee_wbusy,
    output logic              cmd_valid,
    output logic              cmd_err,
    output logic              prog_en,
    output logic              rd_strobe,
    output logic              wel,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [BYTE_W-1:0] prog_data,
    output logic [BYTE_W-1:0] status_reg
);

    cmd_word_u          live_cmd;
    logic [STATE_W-1:0] cur_state;
    logic               bit_last;
    logic               cmd_is_read;
    logic               cmd_is_write;
    logic               cmd_is_wrsr;
    logic               dec_wren;
    logic               dec_wrdi;
    logic               dec_rdsr;
    logic               dec_wrsr;
    logic               dec_read;
    logic               dec_write;
    logic               wren_set;
    logic               wrdi_clr;
    logic               wrsr_commit;
    logic [BYTE_W-1:0]  data_byte;
    logic [1:0]         bp;

    spi_frame_fsm u_frame_fsm (
        .spi_clk_c    (spi_clk_c),
        .spi_frm_rst_n(spi_frm_rst_n),
        .sda_in       (sda_in),
        .dec_wren     (dec_wren),
        .dec_wrdi     (dec_wrdi),
        .dec_rdsr     (dec_rdsr),
        .dec_wrsr     (dec_wrsr),
        .dec_read     (dec_read),
        .dec_write    (dec_write),
        .live_cmd     (live_cmd),
        .cur_state    (cur_state),
        .bit_last     (bit_last),
        .cmd_is_read  (cmd_is_read),
        .cmd_is_write (cmd_is_write),
        .cmd_is_wrsr  (cmd_is_wrsr),
        .wren_set     (wren_set),
        .wrdi_clr     (wrdi_clr),
        .cmd_valid    (cmd_valid),
        .cmd_err      (cmd_err)
    );

    spi_cmd_decode u_cmd_decode (
        .live_cmd (live_cmd),
        .ee_wbusy (ee_wbusy),
        .wel      (wel),
        .dec_wren (dec_wren),
        .dec_wrdi (dec_wrdi),
        .dec_rdsr (dec_rdsr),
        .dec_wrsr (dec_wrsr),
        .dec_read (dec_read),
        .dec_write(dec_write)
    );

    spi_data_path u_data_path (
        .spi_clk_c    (spi_clk_c),
        .spi_frm_rst_n(spi_frm_rst_n),
        .sda_in       (sda_in),
        .cur_state    (cur_state),
        .bit_last     (bit_last),
        .cmd_is_read  (cmd_is_read),
        .cmd_is_write (cmd_is_write),
        .cmd_is_wrsr  (cmd_is_wrsr),
        .bp           (bp),
        .mem_addr     (mem_addr),
        .prog_en      (prog_en),
        .prog_data    (prog_data),
        .rd_strobe    (rd_strobe),
        .wrsr_commit  (wrsr_commit),
        .data_byte    (data_byte)
    );

    spi_status_reg u_status_reg (
        .spi_clk_c    (spi_clk_c),
        .spi_frm_rst_n(spi_frm_rst_n),
        .spi_sys_rst_n(spi_sys_rst_n),
        .spi_wp_n     (spi_wp_n),
        .ee_wbusy     (ee_wbusy),
        .wren_set     (wren_set),
        .wrdi_clr     (wrdi_clr),
        .wrsr_commit  (wrsr_commit),
        .data_byte    (data_byte),
        .wel          (wel),
        .bp           (bp),
        .status_reg   (status_reg)
    );

endmodule

// ==== hdl/spi_status_reg.sv ====
//**************************************************************************
// Status register
//   Write enable latch and stored SRWD and BP bits
//   Sticky hardware write-protect flag, per frame
//   Status byte readout, all ones while busy
//**************************************************************************
`timescale 1ns/1ps
module spi_status_reg import spi_rx_pkg::*; (
    input  logic              spi_clk_c,
    input  logic              spi_frm_rst_n,
    input  logic              spi_sys_rst_n,
    input  logic              spi_wp_n,
    input  logic              ee_wbusy,
    input  logic              wren_set,
    input  logic              wrdi_clr,
    input  logic              wrsr_commit,
    input  logic [BYTE_W-1:0] data_byte,
    output logic              wel,
    output logic [1:0]        bp,
    output logic [BYTE_W-1:0] status_reg
);

    logic              srwd;
    logic              hwp_flag;
    logic [BYTE_W-1:0] sr_word;

    // Latched once the pin is seen low
    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n)
            hwp_flag <= 1'b0;
        else if (!spi_wp_n)
            hwp_flag <= 1'b1;
    end

    always_ff @(posedge spi_clk_c or negedge spi_sys_rst_n) begin
        if (!spi_sys_rst_n) begin
            wel  <= 1'b0;
            srwd <= 1'b0;
            bp   <= 2'b00;
        end else begin
            if (wren_set)
                wel <= 1'b1;
            else if (wrdi_clr)
                wel <= 1'b0;
            // SRWD only locks the register when the pin also protects
            if (wrsr_commit && !(srwd && hwp_flag)) begin
                srwd <= data_byte[SR_SRWD];
                bp   <= data_byte[SR_BP_HI:SR_BP_LO];
            end
        end
    end

    always_comb begin
        sr_word                   = '0;
        sr_word[SR_SRWD]          = srwd;
        sr_word[SR_BP_HI:SR_BP_LO] = bp;
        sr_word[SR_WEL]           = wel;
        sr_word[SR_WIP]           = ee_wbusy;
    end

    assign status_reg = ee_wbusy ? '1 : sr_word;   // Busy reads back 0xFF

endmodule

// ==== sources.f ====
hdl/spi_rx_pkg.sv
hdl/spi_cmd_decode.sv
hdl/spi_frame_fsm.sv
hdl/spi_data_path.sv
hdl/spi_status_reg.sv
hdl/spi_rx_top.sv
testbench/tb_spi_rx.sv

// ==== testbench/tb_spi_rx.sv ====
//**************************************************************************
// Testbench for the receive front end
//   Frame table with stimulus and expected results
//   Bit-serial frame driver and per-edge strobe monitor
//   Compare task and watchdog
//**************************************************************************
`timescale 1ns/1ps
module tb_spi_rx;

    localparam real CLK_PERIOD = 100.0;
    localparam int  NUM_ROWS   = 23;
    localparam int  PAD_BITS   = 2;        // Idle bits after the last byte
    localparam int  WD_CYCLES  = 2 * NUM_ROWS * 48;

    typedef struct packed {
        logic [7:0] cmd;
        logic [7:0] arg;        // Address, or the new status byte for WRSR
        logic [2:0] nbytes;     // Random bytes after arg
        logic       wp_n;
        logic       busy;
        logic       exp_err;
        logic [2:0] exp_prog;
        logic [2:0] exp_rd;
        logic [7:0] exp_addr;   // mem_addr at the first strobe
        logic [7:0] exp_sr;
        logic       exp_wel;
    } row_t;

    logic       spi_clk_c;
    logic       spi_frm_rst_n;
    logic       spi_sys_rst_n;
    logic       sda_in;
    logic       spi_wp_n;
    logic       ee_wbusy;
    logic       cmd_valid;
    logic       cmd_err;
    logic       prog_en;
    logic       rd_strobe;
    logic       wel;
    logic [7:0] mem_addr;
    logic [7:0] prog_data;
    logic [7:0] status_reg;

    row_t       rows [NUM_ROWS];
    row_t       cur;
    int         row_idx;
    logic [7:0] frame_bytes [$];
    int         prog_cnt;
    int         rd_cnt;
    logic [7:0] first_addr;

    spi_rx_top UUT (
        .spi_clk_c    (spi_clk_c),
        .spi_frm_rst_n(spi_frm_rst_n),
        .spi_sys_rst_n(spi_sys_rst_n),
        .sda_in       (sda_in),
        .spi_wp_n     (spi_wp_n),
        .ee_wbusy     (ee_wbusy),
        .cmd_valid    (cmd_valid),
        .cmd_err      (cmd_err),
        .prog_en      (prog_en),
        .rd_strobe    (rd_strobe),
        .wel          (wel),
        .mem_addr     (mem_addr),
        .prog_data    (prog_data),
        .status_reg   (status_reg)
    );

    always #(CLK_PERIOD / 2) spi_clk_c = ~spi_clk_c;

    task automatic expect_eq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: row %0d, %s is 0x%0h, expected 0x%0h",
                     $time, row_idx, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Page base stays, offset wraps inside the 8-byte page
    function automatic logic [7:0] page_addr(input logic [7:0] base, input int k);
        return {base[7:3], 3'((int'(base[2:0]) + k) % 8)};
    endfunction

    // Called 10 ns after edge e of the frame
    task automatic observe_edge(input int e);
        int k;
        if (e < 8)
            expect_eq("cmd_valid before command end", 32'(cmd_valid), 0);
        if (e == 8) begin
            expect_eq("cmd_valid", 32'(cmd_valid), 1);
            expect_eq("cmd_err", 32'(cmd_err), 32'(cur.exp_err));
        end
        if (prog_en) begin
            k = (e - 24) / 8;                  // Data byte k ends at edge 24+8k
            expect_eq("prog_en edge", e, 24 + 8 * k);
            expect_eq("prog_data", 32'(prog_data), 32'(frame_bytes[2 + k]));
            expect_eq("prog mem_addr", 32'(mem_addr), 32'(page_addr(cur.arg, k)));
            if (prog_cnt + rd_cnt == 0)
                first_addr = mem_addr;
            prog_cnt++;
        end
        if (rd_strobe) begin
            k = (e - 16) / 8;                  // Read byte k ends at edge 16+8k
            expect_eq("rd_strobe edge", e, 16 + 8 * k);
            expect_eq("read mem_addr", 32'(mem_addr), 32'(page_addr(cur.arg, k)));
            if (prog_cnt + rd_cnt == 0)
                first_addr = mem_addr;
            rd_cnt++;
        end
    endtask

    //**********************************************************************
    // One frame: reset pulse, command, arg, random bytes, idle bits
    //**********************************************************************
    task automatic run_frame(input int idx);
        int e;
        int i;
        int b;
        cur = rows[idx];
        frame_bytes = {};
        frame_bytes.push_back(cur.cmd);
        frame_bytes.push_back(cur.arg);
        for (i = 0; i < int'(cur.nbytes); i++)
            frame_bytes.push_back(8'($urandom));
        prog_cnt      = 0;
        rd_cnt        = 0;
        first_addr    = '0;
        e             = 0;
        spi_frm_rst_n = 1'b0;                  // Frame boundary
        spi_wp_n      = cur.wp_n;
        ee_wbusy      = cur.busy;
        sda_in        = 1'b0;
        @(posedge spi_clk_c);
        #10;
        spi_frm_rst_n = 1'b1;
        for (i = 0; i < frame_bytes.size(); i++) begin
            for (b = 7; b >= 0; b--) begin     // MSB first
                sda_in = frame_bytes[i][b];
                @(posedge spi_clk_c);
                #10;
                e++;
                observe_edge(e);
            end
        end
        // Status write lands one edge after the byte
        for (b = 0; b < PAD_BITS; b++) begin
            sda_in = 1'($urandom);
            @(posedge spi_clk_c);
            #10;
            e++;
            observe_edge(e);
        end
        expect_eq("prog_en count", prog_cnt, 32'(cur.exp_prog));
        expect_eq("rd_strobe count", rd_cnt, 32'(cur.exp_rd));
        if ((cur.exp_prog != 3'd0) || (cur.exp_rd != 3'd0))
            expect_eq("first mem_addr", 32'(first_addr), 32'(cur.exp_addr));
        expect_eq("status_reg", 32'(status_reg), 32'(cur.exp_sr));
        expect_eq("wel", 32'(wel), 32'(cur.exp_wel));
    endtask

    initial begin
        void'($urandom(7066));
        rows = '{
            //  cmd    arg    n     wp_n  busy  err   prog  rd    addr   sr     wel
            '{8'h02, 8'h10, 3'd2, 1'b1, 1'b0, 1'b1, 3'd0, 3'd0, 8'h00, 8'h00, 1'b0},
            '{8'h06, 8'h00, 3'd0, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h02, 1'b1},
            '{8'h02, 8'h06, 3'd4, 1'b1, 1'b0, 1'b0, 3'd4, 3'd0, 8'h06, 8'h02, 1'b1},
            '{8'h12, 8'h10, 3'd1, 1'b1, 1'b0, 1'b1, 3'd0, 3'd0, 8'h00, 8'h02, 1'b1},
            '{8'h04, 8'h00, 3'd0, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h00, 1'b0},
            '{8'h02, 8'h10, 3'd2, 1'b1, 1'b0, 1'b1, 3'd0, 3'd0, 8'h00, 8'h00, 1'b0},
            '{8'h06, 8'h00, 3'd0, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h02, 1'b1},
            '{8'h01, 8'h08, 3'd0, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h0A, 1'b1},
            '{8'h02, 8'h80, 3'd2, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h0A, 1'b1},
            '{8'h02, 8'hF5, 3'd2, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h0A, 1'b1},
            '{8'h02, 8'h10, 3'd2, 1'b1, 1'b0, 1'b0, 3'd2, 3'd0, 8'h10, 8'h0A, 1'b1},
            '{8'h01, 8'h0C, 3'd0, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h0E, 1'b1},
            '{8'h02, 8'h10, 3'd1, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h0E, 1'b1},
            '{8'h01, 8'h80, 3'd0, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h82, 1'b1},
            '{8'h01, 8'h0C, 3'd0, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h82, 1'b1},
            '{8'h01, 8'h04, 3'd0, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h06, 1'b1},
            '{8'h02, 8'hC2, 3'd1, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h06, 1'b1},
            '{8'h02, 8'h82, 3'd1, 1'b1, 1'b0, 1'b0, 3'd1, 3'd0, 8'h82, 8'h06, 1'b1},
            '{8'h01, 8'h00, 3'd0, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h02, 1'b1},
            '{8'h05, 8'h00, 3'd0, 1'b1, 1'b1, 1'b0, 3'd0, 3'd0, 8'h00, 8'hFF, 1'b1},
            '{8'h04, 8'h00, 3'd0, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'h00, 8'h00, 1'b0},
            '{8'h06, 8'h00, 3'd0, 1'b1, 1'b1, 1'b1, 3'd0, 3'd0, 8'h00, 8'hFF, 1'b0},
            '{8'h03, 8'h3C, 3'd3, 1'b1, 1'b0, 1'b0, 3'd0, 3'd3, 8'h3D, 8'h00, 1'b0}
        };
        spi_clk_c     = 1'b0;
        spi_frm_rst_n = 1'b0;
        spi_sys_rst_n = 1'b0;
        sda_in        = 1'b0;
        spi_wp_n      = 1'b1;
        ee_wbusy      = 1'b0;
        repeat (5) @(posedge spi_clk_c);
        #10;
        spi_frm_rst_n = 1'b1;
        spi_sys_rst_n = 1'b1;                  // Only released once per run
        for (row_idx = 0; row_idx < NUM_ROWS; row_idx++)
            run_frame(row_idx);
        $display("Simulation completed successfully");
        $finish;
    end

    // Twice the worst-case frame length per table row
    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("timeout: the frame table did not finish in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule
